//--- src/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath widths
`define MIPS_XLEN      32
`define MIPS_REG_AW    5

// first fetch address after reset
`define MIPS_RESET_PC  32'h0000_0000

// low bit of each instruction field
`define MIPS_RS_LSB    21
`define MIPS_RT_LSB    16
`define MIPS_RD_LSB    11
`define MIPS_SHAMT_LSB 6
`define MIPS_OPC_LSB   26

`endif

//--- src/mipsPkg.sv
`include "mips_defs.svh"

package mipsPkg;

    typedef logic [`MIPS_XLEN-1:0]   wordT;
    typedef logic [`MIPS_REG_AW-1:0] regAddrT;

    // major opcodes, MIPS encodings
    typedef enum logic [5:0] {
        OPC_RTYPE = 6'h00,
        OPC_J     = 6'h02,
        OPC_BEQ   = 6'h04,
        OPC_BNE   = 6'h05,
        OPC_ADDI  = 6'h08,
        OPC_ANDI  = 6'h0c,
        OPC_ORI   = 6'h0d,
        OPC_LUI   = 6'h0f,
        OPC_LW    = 6'h23,
        OPC_SW    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOpT;

    // source of an execute operand
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSelT;

endpackage

//--- src/regFile.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module regFile
    import mipsPkg::*;
(
    input  logic    clk_i,
    input  logic    rstN_i,
    input  logic    we_i,
    input  regAddrT waddr_i,
    input  wordT    wdata_i,
    input  regAddrT raddrA_i,
    input  regAddrT raddrB_i,
    output wordT    rdataA_o,
    output wordT    rdataB_o
);

    wordT regs [2**`MIPS_REG_AW];

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < 2**`MIPS_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i; // $0 never written
        end
    end

    // same-cycle writeback is passed straight to decode
    assign rdataA_o = (raddrA_i == '0) ? '0 :
                      (we_i && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 :
                      (we_i && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

//--- src/fetchStage.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module fetchStage
    import mipsPkg::*;
(
    input  logic clk_i,
    input  logic rstN_i,
    input  logic stallF_i,
    input  logic flushD_i,
    input  logic freeze_i,
    input  logic jumpD_i,
    input  wordT jumpTargetD_i,
    input  logic branchTakenE_i,
    input  wordT branchTargetE_i,
    input  wordT iMemData_i,
    output wordT iMemAddr_o,
    output wordT instrD_o,
    output wordT pcPlus4D_o
);

    wordT pc;
    wordT pcPlus4;
    wordT pcNext;

    assign pcPlus4    = pc + wordT'(4);
    assign iMemAddr_o = pc;

    // branch from execute beats jump from decode
    always_comb begin
        if (branchTakenE_i) begin
            pcNext = branchTargetE_i;
        end else if (jumpD_i) begin
            pcNext = jumpTargetD_i;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pc <= `MIPS_RESET_PC;
        end else if (!freeze_i && !stallF_i) begin
            pc <= pcNext;
        end
    end

    // fetch/decode register, zero word decodes as nop
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            instrD_o <= '0;
        end else if (!freeze_i) begin
            if (flushD_i) begin
                instrD_o <= '0;
            end else if (!stallF_i) begin
                instrD_o <= iMemData_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_i && !stallF_i) begin
            pcPlus4D_o <= pcPlus4;
        end
    end

endmodule

//--- src/decodeStage.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module decodeStage
    import mipsPkg::*;
(
    input  logic    clk_i,
    input  logic    rstN_i,
    input  logic    flushE_i,
    input  logic    stallD_i,
    input  logic    freeze_i,
    input  wordT    instrD_i,
    input  wordT    pcPlus4D_i,
    input  logic    regWriteW_i,
    input  regAddrT writeRegW_i,
    input  wordT    resultW_i,
    output regAddrT rsD_o,
    output regAddrT rtD_o,
    output logic    jumpD_o,
    output wordT    jumpTargetD_o,
    output aluOpT   aluOpE_o,
    output logic    useImmE_o,
    output logic    memReadE_o,
    output logic    memWriteE_o,
    output logic    regWriteE_o,
    output logic    branchE_o,
    output logic    branchNeE_o,
    output wordT    rdValAE_o,
    output wordT    rdValBE_o,
    output wordT    immE_o,
    output regAddrT shamtE_o,
    output regAddrT rsE_o,
    output regAddrT rtE_o,
    output regAddrT writeRegE_o,
    output wordT    pcPlus4E_o
);

    opcodeT  opcode;
    functT   funct;
    regAddrT rdD;
    wordT    rdValA;
    wordT    rdValB;
    wordT    immD;
    aluOpT   aluOpD;
    logic    useImmD;
    logic    memReadD;
    logic    memWriteD;
    logic    regWriteD;
    logic    branchD;
    logic    branchNeD;
    logic    signExtD;
    logic    regDstRdD; // rd for R-type, rt otherwise

    assign opcode = opcodeT'(instrD_i[`MIPS_OPC_LSB +: 6]);
    assign funct  = functT'(instrD_i[5:0]);
    assign rsD_o  = instrD_i[`MIPS_RS_LSB +: `MIPS_REG_AW];
    assign rtD_o  = instrD_i[`MIPS_RT_LSB +: `MIPS_REG_AW];
    assign rdD    = instrD_i[`MIPS_RD_LSB +: `MIPS_REG_AW];

    always_comb begin
        aluOpD    = ALU_ADD;
        useImmD   = 1'b0;
        memReadD  = 1'b0;
        memWriteD = 1'b0;
        regWriteD = 1'b0;
        branchD   = 1'b0;
        branchNeD = 1'b0;
        signExtD  = 1'b0;
        regDstRdD = 1'b0;
        jumpD_o   = 1'b0;
        case (opcode)
            OPC_RTYPE: begin
                regDstRdD = 1'b1;
                regWriteD = 1'b1;
                case (funct)
                    FN_SLL:  aluOpD = ALU_SLL;
                    FN_ADD:  aluOpD = ALU_ADD;
                    FN_SUB:  aluOpD = ALU_SUB;
                    FN_AND:  aluOpD = ALU_AND;
                    FN_OR:   aluOpD = ALU_OR;
                    FN_XOR:  aluOpD = ALU_XOR;
                    FN_SLT:  aluOpD = ALU_SLT;
                    default: regWriteD = 1'b0; // unsupported funct
                endcase
            end
            OPC_J: jumpD_o = 1'b1;
            OPC_BEQ, OPC_BNE: begin
                branchD   = 1'b1;
                branchNeD = (opcode == OPC_BNE);
                signExtD  = 1'b1;
            end
            OPC_ADDI: begin
                useImmD   = 1'b1;
                signExtD  = 1'b1;
                regWriteD = 1'b1;
            end
            OPC_ANDI, OPC_ORI, OPC_LUI: begin
                useImmD   = 1'b1;
                regWriteD = 1'b1;
                aluOpD    = (opcode == OPC_ANDI) ? ALU_AND :
                            (opcode == OPC_ORI) ? ALU_OR : ALU_LUI;
            end
            OPC_LW, OPC_SW: begin
                useImmD   = 1'b1;
                signExtD  = 1'b1;
                memReadD  = (opcode == OPC_LW);
                memWriteD = (opcode == OPC_SW);
                regWriteD = (opcode == OPC_LW);
            end
            default: ; // anything else is a nop
        endcase
    end

    assign immD = signExtD ? {{(`MIPS_XLEN-16){instrD_i[15]}}, instrD_i[15:0]}
                           : {{(`MIPS_XLEN-16){1'b0}}, instrD_i[15:0]};
    assign jumpTargetD_o = {pcPlus4D_i[31:28], instrD_i[25:0], 2'b00};

    regFile i_regFile (
        .clk_i    (clk_i),
        .rstN_i   (rstN_i),
        .we_i     (regWriteW_i && !freeze_i),
        .waddr_i  (writeRegW_i),
        .wdata_i  (resultW_i),
        .raddrA_i (rsD_o),
        .raddrB_i (rtD_o),
        .rdataA_o (rdValA),
        .rdataB_o (rdValB)
    );

    // decode/execute control, flush inserts a bubble
    always_ff @(posedge clk_i) begin
        if (!rstN_i || (!freeze_i && flushE_i)) begin
            aluOpE_o    <= ALU_ADD;
            useImmE_o   <= 1'b0;
            memReadE_o  <= 1'b0;
            memWriteE_o <= 1'b0;
            regWriteE_o <= 1'b0;
            branchE_o   <= 1'b0;
            branchNeE_o <= 1'b0;
        end else if (!freeze_i) begin
            aluOpE_o    <= aluOpD;
            useImmE_o   <= useImmD;
            memReadE_o  <= memReadD;
            memWriteE_o <= memWriteD;
            regWriteE_o <= regWriteD;
            branchE_o   <= branchD;
            branchNeE_o <= branchNeD;
        end
    end

    // payload keeps its old value while decode is stalled
    always_ff @(posedge clk_i) begin
        if (!freeze_i && !stallD_i) begin
            rdValAE_o   <= rdValA;
            rdValBE_o   <= rdValB;
            immE_o      <= immD;
            shamtE_o    <= instrD_i[`MIPS_SHAMT_LSB +: `MIPS_REG_AW];
            rsE_o       <= rsD_o;
            rtE_o       <= rtD_o;
            writeRegE_o <= regDstRdD ? rdD : rtD_o;
            pcPlus4E_o  <= pcPlus4D_i;
        end
    end

endmodule

//--- src/executeStage.sv
`timescale 1ns/1ps

module executeStage
    import mipsPkg::*;
(
    input  logic    clk_i,
    input  logic    rstN_i,
    input  logic    freeze_i,
    input  fwdSelT  fwdSelA_i,
    input  fwdSelT  fwdSelB_i,
    input  aluOpT   aluOpE_i,
    input  logic    useImmE_i,
    input  logic    memReadE_i,
    input  logic    memWriteE_i,
    input  logic    regWriteE_i,
    input  logic    branchE_i,
    input  logic    branchNeE_i,
    input  wordT    rdValAE_i,
    input  wordT    rdValBE_i,
    input  wordT    immE_i,
    input  regAddrT shamtE_i,
    input  regAddrT writeRegE_i,
    input  wordT    pcPlus4E_i,
    input  wordT    aluResultM_i,
    input  wordT    resultW_i,
    output logic    branchTakenE_o,
    output wordT    branchTargetE_o,
    output wordT    aluResultM_o,
    output wordT    storeDataM_o,
    output logic    memReadM_o,
    output logic    memWriteM_o,
    output logic    regWriteM_o,
    output regAddrT writeRegM_o
);

    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluResult;

    always_comb begin
        case (fwdSelA_i)
            FWD_MEM: opA = aluResultM_i;
            FWD_WB:  opA = resultW_i;
            default: opA = rdValAE_i;
        endcase
        case (fwdSelB_i)
            FWD_MEM: opB = aluResultM_i;
            FWD_WB:  opB = resultW_i;
            default: opB = rdValBE_i;
        endcase
    end

    assign aluB = useImmE_i ? immE_i : opB;

    always_comb begin
        case (aluOpE_i)
            ALU_SUB: aluResult = opA - aluB;
            ALU_AND: aluResult = opA & aluB;
            ALU_OR:  aluResult = opA | aluB;
            ALU_XOR: aluResult = opA ^ aluB;
            ALU_SLT: aluResult = wordT'($signed(opA) < $signed(aluB));
            ALU_SLL: aluResult = aluB << shamtE_i;  // shifts rt
            ALU_LUI: aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = opA + aluB;
        endcase
    end

    assign branchTakenE_o  = branchE_i && ((opA == opB) != branchNeE_i);
    assign branchTargetE_o = pcPlus4E_i + {immE_i[29:0], 2'b00};

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            memReadM_o  <= 1'b0;
            memWriteM_o <= 1'b0;
            regWriteM_o <= 1'b0;
        end else if (!freeze_i) begin
            memReadM_o  <= memReadE_i;
            memWriteM_o <= memWriteE_i;
            regWriteM_o <= regWriteE_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            aluResultM_o <= aluResult;
            storeDataM_o <= opB;   // forwarded rt
            writeRegM_o  <= writeRegE_i;
        end
    end

endmodule

//--- src/memoryStage.sv
`timescale 1ns/1ps

module memoryStage
    import mipsPkg::*;
(
    input  logic    clk_i,
    input  logic    rstN_i,
    input  logic    freeze_i,
    input  wordT    aluResultM_i,
    input  wordT    storeDataM_i,
    input  logic    memReadM_i,
    input  logic    memWriteM_i,
    input  logic    regWriteM_i,
    input  regAddrT writeRegM_i,
    input  wordT    dMemRdata_i,
    output logic    dMemEn_o,
    output logic    dMemWe_o,
    output wordT    dMemAddr_o,
    output wordT    dMemWdata_o,
    output logic    regWriteW_o,
    output regAddrT writeRegW_o,
    output wordT    resultW_o,
    output logic    wbValid_o
);

    wordT resultM;

    // data port held steady by the frozen register
    assign dMemEn_o    = memReadM_i || memWriteM_i;
    assign dMemWe_o    = memWriteM_i;
    assign dMemAddr_o  = aluResultM_i;
    assign dMemWdata_o = storeDataM_i;

    assign resultM = memReadM_i ? dMemRdata_i : aluResultM_i;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            regWriteW_o <= 1'b0;
        end else if (!freeze_i) begin
            regWriteW_o <= regWriteM_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!freeze_i) begin
            writeRegW_o <= writeRegM_i;
            resultW_o   <= resultM;
        end
    end

    // one pulse per commit, after the freeze lifts
    assign wbValid_o = regWriteW_o && !freeze_i && (writeRegW_o != '0);

endmodule

//--- src/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
    import mipsPkg::*;
(
    input  regAddrT rsD_i,
    input  regAddrT rtD_i,
    input  regAddrT rsE_i,
    input  regAddrT rtE_i,
    input  logic    memReadE_i,
    input  regAddrT writeRegE_i,
    input  logic    branchTakenE_i,
    input  logic    jumpD_i,
    input  logic    regWriteM_i,
    input  regAddrT writeRegM_i,
    input  logic    regWriteW_i,
    input  regAddrT writeRegW_i,
    input  logic    dataStall_i,
    output logic    stallF_o,
    output logic    stallD_o,
    output logic    flushD_o,
    output logic    flushE_o,
    output logic    freeze_o,
    output fwdSelT  fwdSelA_o,
    output fwdSelT  fwdSelB_o
);

    logic loadUse;

    // youngest producer wins, $0 is never forwarded
    function automatic fwdSelT pickFwd(regAddrT src);
        if (src != '0 && regWriteM_i && writeRegM_i == src) begin
            return FWD_MEM;
        end else if (src != '0 && regWriteW_i && writeRegW_i == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign loadUse = memReadE_i && (writeRegE_i != '0) &&
                     (writeRegE_i == rsD_i || writeRegE_i == rtD_i);

    assign stallF_o = loadUse && !branchTakenE_i;
    assign stallD_o = loadUse && !branchTakenE_i;
    assign flushD_o = branchTakenE_i || (jumpD_i && !stallD_o); // stalled jump retries
    assign flushE_o = branchTakenE_i || loadUse;
    assign freeze_o = dataStall_i;

    always_comb begin
        fwdSelA_o = pickFwd(rsE_i);
        fwdSelB_o = pickFwd(rtE_i);
    end

endmodule

//--- src/mipsCore.sv
`timescale 1ns/1ps

module mipsCore
    import mipsPkg::*;
(
    input  logic    clk_i,
    input  logic    rstN_i,
    output wordT    iMemAddr_o,
    input  wordT    iMemData_i,
    output logic    dMemEn_o,
    output logic    dMemWe_o,
    output wordT    dMemAddr_o,
    output wordT    dMemWdata_o,
    input  wordT    dMemRdata_i,
    input  logic    dataStall_i,
    output logic    wbValid_o,
    output regAddrT wbReg_o,
    output wordT    wbData_o
);

    // hazard control
    logic    stallF, stallD, flushD, flushE, freeze;
    fwdSelT  fwdSelA, fwdSelB;
    // fetch/decode
    wordT    instrD, pcPlus4D, jumpTargetD;
    logic    jumpD;
    regAddrT rsD, rtD;
    // decode/execute
    aluOpT   aluOpE;
    logic    useImmE, memReadE, memWriteE, regWriteE, branchE, branchNeE;
    wordT    rdValAE, rdValBE, immE, pcPlus4E;
    regAddrT shamtE, rsE, rtE, writeRegE;
    logic    branchTakenE;
    wordT    branchTargetE;
    // execute/memory
    wordT    aluResultM, storeDataM;
    logic    memReadM, memWriteM, regWriteM;
    regAddrT writeRegM;
    // memory/writeback
    logic    regWriteW;
    regAddrT writeRegW;
    wordT    resultW;

    assign wbReg_o  = writeRegW;
    assign wbData_o = resultW;

    fetchStage i_fetchStage (
        .clk_i(clk_i), .rstN_i(rstN_i), .stallF_i(stallF), .flushD_i(flushD),
        .freeze_i(freeze), .jumpD_i(jumpD), .jumpTargetD_i(jumpTargetD),
        .branchTakenE_i(branchTakenE), .branchTargetE_i(branchTargetE),
        .iMemData_i(iMemData_i), .iMemAddr_o(iMemAddr_o),
        .instrD_o(instrD), .pcPlus4D_o(pcPlus4D)
    );

    decodeStage i_decodeStage (
        .clk_i(clk_i), .rstN_i(rstN_i), .flushE_i(flushE), .stallD_i(stallD),
        .freeze_i(freeze), .instrD_i(instrD), .pcPlus4D_i(pcPlus4D),
        .regWriteW_i(regWriteW), .writeRegW_i(writeRegW), .resultW_i(resultW),
        .rsD_o(rsD), .rtD_o(rtD), .jumpD_o(jumpD), .jumpTargetD_o(jumpTargetD),
        .aluOpE_o(aluOpE), .useImmE_o(useImmE), .memReadE_o(memReadE),
        .memWriteE_o(memWriteE), .regWriteE_o(regWriteE), .branchE_o(branchE),
        .branchNeE_o(branchNeE), .rdValAE_o(rdValAE), .rdValBE_o(rdValBE),
        .immE_o(immE), .shamtE_o(shamtE), .rsE_o(rsE), .rtE_o(rtE),
        .writeRegE_o(writeRegE), .pcPlus4E_o(pcPlus4E)
    );

    executeStage i_executeStage (
        .clk_i(clk_i), .rstN_i(rstN_i), .freeze_i(freeze),
        .fwdSelA_i(fwdSelA), .fwdSelB_i(fwdSelB), .aluOpE_i(aluOpE),
        .useImmE_i(useImmE), .memReadE_i(memReadE), .memWriteE_i(memWriteE),
        .regWriteE_i(regWriteE), .branchE_i(branchE), .branchNeE_i(branchNeE),
        .rdValAE_i(rdValAE), .rdValBE_i(rdValBE), .immE_i(immE), .shamtE_i(shamtE),
        .writeRegE_i(writeRegE), .pcPlus4E_i(pcPlus4E),
        .aluResultM_i(aluResultM), .resultW_i(resultW),
        .branchTakenE_o(branchTakenE), .branchTargetE_o(branchTargetE),
        .aluResultM_o(aluResultM), .storeDataM_o(storeDataM),
        .memReadM_o(memReadM), .memWriteM_o(memWriteM),
        .regWriteM_o(regWriteM), .writeRegM_o(writeRegM)
    );

    memoryStage i_memoryStage (
        .clk_i(clk_i), .rstN_i(rstN_i), .freeze_i(freeze),
        .aluResultM_i(aluResultM), .storeDataM_i(storeDataM),
        .memReadM_i(memReadM), .memWriteM_i(memWriteM),
        .regWriteM_i(regWriteM), .writeRegM_i(writeRegM),
        .dMemRdata_i(dMemRdata_i), .dMemEn_o(dMemEn_o), .dMemWe_o(dMemWe_o),
        .dMemAddr_o(dMemAddr_o), .dMemWdata_o(dMemWdata_o),
        .regWriteW_o(regWriteW), .writeRegW_o(writeRegW),
        .resultW_o(resultW), .wbValid_o(wbValid_o)
    );

    hazardUnit i_hazardUnit (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
        .memReadE_i(memReadE), .writeRegE_i(writeRegE),
        .branchTakenE_i(branchTakenE), .jumpD_i(jumpD),
        .regWriteM_i(regWriteM), .writeRegM_i(writeRegM),
        .regWriteW_i(regWriteW), .writeRegW_i(writeRegW),
        .dataStall_i(dataStall_i),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .freeze_o(freeze), .fwdSelA_o(fwdSelA), .fwdSelB_o(fwdSelB)
    );

endmodule

//--- verification/tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore
    import mipsPkg::*;
();

    localparam int MemWords  = 256;
    localparam int MaxCycles = 300; // per program, stalls included

    logic    clk;
    logic    rstN;
    logic    dataStall;
    wordT    iMemAddr, iMemData;
    logic    dMemEn, dMemWe;
    wordT    dMemAddr, dMemWdata, dMemRdata;
    logic    wbValid;
    regAddrT wbReg;
    wordT    wbData;

    wordT    imem [MemWords];
    wordT    dmem [MemWords];
    int      storeCount;
    bit      stallEnable;

    wordT    prog[$];
    regAddrT expReg[$];
    wordT    expData[$];
    regAddrT gotReg[$];
    wordT    gotData[$];

    string   testName;
    int      testErrors;
    int      testsRun;
    int      testsFailed;

    mipsCore i_mipsCore (
        .clk_i(clk), .rstN_i(rstN), .iMemAddr_o(iMemAddr), .iMemData_i(iMemData),
        .dMemEn_o(dMemEn), .dMemWe_o(dMemWe), .dMemAddr_o(dMemAddr),
        .dMemWdata_o(dMemWdata), .dMemRdata_i(dMemRdata), .dataStall_i(dataStall),
        .wbValid_o(wbValid), .wbReg_o(wbReg), .wbData_o(wbData)
    );

    always #4 clk = ~clk;

    // both memories answer in the same cycle
    assign iMemData  = imem[iMemAddr[9:2]];
    assign dMemRdata = dmem[dMemAddr[9:2]];

    function automatic wordT fillWord(int idx);
        return 32'ha500_0000 ^ (idx * 32'h0001_0101);
    endfunction

    // data memory refills on reset, stores land only when not stalled
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < MemWords; i++) begin
                dmem[i] <= fillWord(i);
            end
            storeCount <= 0;
        end else if (dMemEn && dMemWe && !dataStall) begin
            dmem[dMemAddr[9:2]] <= dMemWdata;
            storeCount <= storeCount + 1;
        end
    end

    always @(posedge clk) begin
        if (stallEnable) begin
            dataStall <= ($urandom % 3) == 0; // roughly one cycle in three
        end else begin
            dataStall <= 1'b0;
        end
    end

    function automatic wordT rType(functT fn, regAddrT rd, regAddrT rs, regAddrT rt,
                                   logic [4:0] sh);
        return {OPC_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    // rt is the destination, or the second compare operand of a branch
    function automatic wordT iType(opcodeT opc, regAddrT rt, regAddrT rs,
                                   logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic wordT jType(logic [25:0] target);
        return {OPC_J, target};
    endfunction

    task automatic emit(input wordT instr);
        prog.push_back(instr);
    endtask

    task automatic expectWb(input regAddrT r, input wordT d);
        expReg.push_back(r);
        expData.push_back(d);
    endtask

    task automatic checkWord(input string what, input wordT expected, input wordT actual);
        if (actual !== expected) begin
            $display("FAIL %s: %s expected %h, actual %h", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkReg(input string what, input regAddrT expected,
                            input regAddrT actual);
        if (actual !== expected) begin
            $display("FAIL %s: %s expected %0d, actual %0d", testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
        prog.delete();
        expReg.delete();
        expData.delete();
    endtask

    task automatic resetCore();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    endtask

    // loads the program with an end marker, resets, collects writebacks
    task automatic runProgram(input bit withStalls);
        bit done;
        int n;
        for (int i = 0; i < MemWords; i++) begin
            imem[i] = '0; // zero word is a nop
        end
        for (int i = 0; i < prog.size(); i++) begin
            imem[i] = prog[i];
        end
        imem[prog.size()] = iType(OPC_ORI, 5'd31, 5'd0, 16'h600d);
        stallEnable = withStalls;
        gotReg.delete();
        gotData.delete();
        resetCore();
        done = 1'b0;
        for (int cyc = 0; cyc < MaxCycles && !done; cyc++) begin
            @(negedge clk);
            if (wbValid && wbReg == 5'd31) begin
                done = 1'b1;
            end else if (wbValid) begin
                gotReg.push_back(wbReg);
                gotData.push_back(wbData);
            end
        end
        stallEnable = 1'b0;
        if (!done) begin
            $display("%s: timed out waiting for the end marker to write back", testName);
            testErrors++;
        end
        if (gotReg.size() != expReg.size()) begin
            $display("FAIL %s: writeback count expected %0d, actual %0d",
                     testName, expReg.size(), gotReg.size());
            testErrors++;
        end
        n = (gotReg.size() < expReg.size()) ? gotReg.size() : expReg.size();
        for (int i = 0; i < n; i++) begin
            checkReg($sformatf("writeback %0d reg", i), expReg[i], gotReg[i]);
            checkWord($sformatf("writeback %0d data", i), expData[i], gotData[i]);
        end
    endtask

    task automatic endTest();
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
            $display("%s: %0d check(s) failed", testName, testErrors);
        end else begin
            $display("%s: ok", testName);
        end
    endtask

    task automatic testAluChain();
        startTest("testAluChain");
        emit(iType(OPC_ADDI, 5'd1, 5'd0, 16'd5));       expectWb(5'd1, 32'd5);
        emit(iType(OPC_ADDI, 5'd2, 5'd1, 16'd3));       expectWb(5'd2, 32'd8);
        emit(rType(FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0));    expectWb(5'd3, 32'd13);
        emit(rType(FN_SUB, 5'd4, 5'd3, 5'd1, 5'd0));    expectWb(5'd4, 32'd8);
        emit(rType(FN_XOR, 5'd5, 5'd4, 5'd2, 5'd0));    expectWb(5'd5, 32'd0);
        emit(iType(OPC_ORI, 5'd6, 5'd5, 16'hf0f0));     expectWb(5'd6, 32'h0000_f0f0);
        emit(iType(OPC_LUI, 5'd7, 5'd0, 16'h1234));     expectWb(5'd7, 32'h1234_0000);
        emit(rType(FN_OR, 5'd8, 5'd7, 5'd6, 5'd0));     expectWb(5'd8, 32'h1234_f0f0);
        emit(iType(OPC_ANDI, 5'd9, 5'd8, 16'h0ff0));    expectWb(5'd9, 32'h0000_00f0);
        emit(iType(OPC_ADDI, 5'd10, 5'd0, 16'hffff));   expectWb(5'd10, 32'hffff_ffff);
        emit(rType(FN_SLT, 5'd11, 5'd10, 5'd4, 5'd0));  expectWb(5'd11, 32'd1);
        emit(rType(FN_SLL, 5'd12, 5'd0, 5'd11, 5'd4));  expectWb(5'd12, 32'h10);
        emit(rType(FN_SLT, 5'd13, 5'd4, 5'd10, 5'd0));  expectWb(5'd13, 32'd0);
        runProgram(1'b0);
        endTest();
    endtask

    task automatic testLoadStore();
        startTest("testLoadStore");
        emit(iType(OPC_ADDI, 5'd1, 5'd0, 16'h1234));    expectWb(5'd1, 32'h1234);
        emit(iType(OPC_ADDI, 5'd2, 5'd0, 16'h0040));    expectWb(5'd2, 32'h40);
        emit(iType(OPC_SW, 5'd1, 5'd2, 16'd4));
        emit(iType(OPC_LW, 5'd3, 5'd2, 16'd4));         expectWb(5'd3, 32'h1234);
        emit(rType(FN_ADD, 5'd4, 5'd3, 5'd1, 5'd0));    expectWb(5'd4, 32'h2468);
        emit(iType(OPC_SW, 5'd4, 5'd2, 16'd8));
        emit(iType(OPC_LW, 5'd5, 5'd2, 16'd8));         expectWb(5'd5, 32'h2468);
        emit(iType(OPC_LW, 5'd6, 5'd2, 16'd0));         expectWb(5'd6, fillWord(16));
        runProgram(1'b0);
        checkWord("word at 0x44", 32'h1234, dmem[17]);
        checkWord("word at 0x48", 32'h2468, dmem[18]);
        endTest();
    endtask

    task automatic testBranch();
        startTest("testBranch");
        emit(iType(OPC_ADDI, 5'd1, 5'd0, 16'd7));       expectWb(5'd1, 32'd7);
        emit(iType(OPC_ADDI, 5'd2, 5'd0, 16'd7));       expectWb(5'd2, 32'd7);
        emit(iType(OPC_BEQ, 5'd2, 5'd1, 16'd2));        // taken
        emit(iType(OPC_ADDI, 5'd3, 5'd0, 16'd1));
        emit(iType(OPC_ADDI, 5'd3, 5'd0, 16'd2));
        emit(iType(OPC_ADDI, 5'd4, 5'd0, 16'd3));       expectWb(5'd4, 32'd3);
        emit(iType(OPC_BNE, 5'd2, 5'd1, 16'd1));        // not taken
        emit(iType(OPC_ADDI, 5'd5, 5'd0, 16'd4));       expectWb(5'd5, 32'd4);
        emit(iType(OPC_BEQ, 5'd4, 5'd1, 16'd1));        // not taken
        emit(iType(OPC_ADDI, 5'd6, 5'd0, 16'd5));       expectWb(5'd6, 32'd5);
        emit(iType(OPC_BNE, 5'd4, 5'd1, 16'd2));        // taken
        emit(iType(OPC_ADDI, 5'd7, 5'd0, 16'd6));
        emit(iType(OPC_ADDI, 5'd7, 5'd0, 16'd7));
        emit(iType(OPC_ADDI, 5'd8, 5'd0, 16'd8));       expectWb(5'd8, 32'd8);
        runProgram(1'b0);
        endTest();
    endtask

    task automatic testJump();
        startTest("testJump");
        emit(iType(OPC_ADDI, 5'd1, 5'd0, 16'd1));       expectWb(5'd1, 32'd1);
        emit(jType(26'd3));
        emit(iType(OPC_ADDI, 5'd2, 5'd0, 16'd2));       // skipped
        emit(iType(OPC_ADDI, 5'd3, 5'd0, 16'd3));       expectWb(5'd3, 32'd3);
        emit(jType(26'd6));
        emit(iType(OPC_ADDI, 5'd4, 5'd0, 16'd4));       // skipped
        emit(iType(OPC_ADDI, 5'd5, 5'd0, 16'd5));       expectWb(5'd5, 32'd5);
        runProgram(1'b0);
        endTest();
    endtask

    task automatic testDataStall();
        startTest("testDataStall");
        emit(iType(OPC_ADDI, 5'd1, 5'd0, 16'h0080));    expectWb(5'd1, 32'h80);
        emit(iType(OPC_ADDI, 5'd2, 5'd0, 16'h0011));    expectWb(5'd2, 32'h11);
        emit(iType(OPC_SW, 5'd2, 5'd1, 16'd0));
        emit(iType(OPC_LW, 5'd3, 5'd1, 16'd0));         expectWb(5'd3, 32'h11);
        emit(iType(OPC_ADDI, 5'd4, 5'd3, 16'h0022));    expectWb(5'd4, 32'h33);
        emit(iType(OPC_SW, 5'd4, 5'd1, 16'd4));
        emit(iType(OPC_LW, 5'd5, 5'd1, 16'd4));         expectWb(5'd5, 32'h33);
        emit(iType(OPC_SW, 5'd5, 5'd1, 16'd8));         // load-use on store data
        emit(iType(OPC_LW, 5'd6, 5'd1, 16'd8));         expectWb(5'd6, 32'h33);
        emit(rType(FN_ADD, 5'd7, 5'd6, 5'd3, 5'd0));    expectWb(5'd7, 32'h44);
        runProgram(1'b1);
        checkWord("word at 0x80", 32'h11, dmem[32]);
        checkWord("word at 0x84", 32'h33, dmem[33]);
        checkWord("word at 0x88", 32'h33, dmem[34]);
        checkWord("word at 0x8c", fillWord(35), dmem[35]);
        checkWord("store count", 32'd3, wordT'(storeCount));
        endTest();
    endtask

    task automatic testZeroReg();
        startTest("testZeroReg");
        emit(iType(OPC_ADDI, 5'd0, 5'd0, 16'd5));
        emit(iType(OPC_ADDI, 5'd1, 5'd0, 16'd9));       expectWb(5'd1, 32'd9);
        emit(rType(FN_ADD, 5'd0, 5'd1, 5'd1, 5'd0));
        emit(rType(FN_ADD, 5'd2, 5'd0, 5'd1, 5'd0));    expectWb(5'd2, 32'd9);
        emit(iType(OPC_LW, 5'd0, 5'd0, 16'd0));
        emit(rType(FN_OR, 5'd3, 5'd0, 5'd0, 5'd0));     expectWb(5'd3, 32'd0);
        emit(iType(OPC_ORI, 5'd4, 5'd0, 16'h0055));     expectWb(5'd4, 32'h55);
        runProgram(1'b0);
        endTest();
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        dataStall   = 1'b0;
        stallEnable = 1'b0;
        testsRun    = 0;
        testsFailed = 0;
        void'($urandom(32'h2cb24e1b));
        testAluChain();
        testLoadStore();
        testBranch();
        testJump();
        testDataStall();
        testZeroReg();
        $display("tests run %0d, tests with errors %0d", testsRun, testsFailed);
        if (testsFailed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/mipsPkg.sv
src/regFile.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/mipsCore.sv
verification/tbMipsCore.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - src
    files:
      - src/mipsPkg.sv
      - src/regFile.sv
      - src/fetchStage.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/memoryStage.sv
      - src/hazardUnit.sv
      - src/mipsCore.sv
  - target: test
    files:
      - verification/tbMipsCore.sv
